/* chipCheckPkg.sv */
package chipCheckPkg;

	// ==================================================
	// socket and display widths
	// ==================================================
	localparam int PinCount = 14;   // pins 7 and 14 are power

	typedef logic [PinCount-1:0] pinVecT;   // bit i-1 is socket pin i
	typedef logic [7:0] selCodeT;           // chip code as two hex digits
	typedef logic [3:0] nibbleT;
	typedef logic [6:0] segT;               // active low, bit 0 = seg a
	typedef logic [1:0] vecIdxT;            // input vector index, a = bit 0, b = bit 1

	// supported codes
	localparam selCodeT Code7400 = 8'h00;
	localparam selCodeT Code7402 = 8'h02;
	localparam selCodeT Code7404 = 8'h04;
	localparam selCodeT Code7486 = 8'h86;

	// ==================================================
	// enums
	// ==================================================
	typedef enum logic [2:0] {
		chipNone,
		chip7400,
		chip7402,
		chip7404,
		chip7486
	} chipT;

	typedef enum logic [1:0] {
		stIdle,
		stTest,
		stShow
	} ctrlStateT;

endpackage

/* checkIf.sv */
interface checkIf;
	import chipCheckPkg::*;

	chipT chip;       // decoded chip kind
	pinVecT oeMask;   // 1 = chip input pin, driven by tester
	logic start;      // one cycle, from control
	logic done;       // one cycle, answers start once
	logic pass;       // valid with done

	modport decode (output chip, output oeMask);

	modport ctrl (input chip, output start, input done, input pass);

	modport tester (input chip, input oeMask, input start, output done, output pass);

endinterface

/* chipDecode.sv */
module chipDecode (
	input chipCheckPkg::selCodeT code,
	checkIf.decode job
);
	import chipCheckPkg::*;

	// input pins are 1, outputs and power 0
	always_comb
	begin
		case (code)
			Code7400:
			begin
				job.chip = chip7400;
				job.oeMask = 14'b01_1011_0001_1011;   // pins 1,2 4,5 9,10 12,13
			end
			Code7402:
			begin
				job.chip = chip7402;
				job.oeMask = 14'b00_1101_1011_0110;   // pins 2,3 5,6 8,9 11,12
			end
			Code7404:
			begin
				job.chip = chip7404;
				job.oeMask = 14'b01_0101_0001_0101;   // pins 1 3 5 9 11 13
			end
			Code7486:
			begin
				job.chip = chip7486;
				job.oeMask = 14'b01_1011_0001_1011;   // same pinout as 7400
			end
			default:
			begin
				// unknown part, keep every pin released
				job.chip = chipNone;
				job.oeMask = '0;
			end
		endcase
	end

endmodule

/* checkControl.sv */
module checkControl (
	input logic Clk,
	input logic arstN,
	input logic run,
	input chipCheckPkg::selCodeT sel,
	output chipCheckPkg::selCodeT code,
	checkIf.ctrl job,
	output logic busy,
	output logic done,
	output logic showing,
	output logic verdict
);
	import chipCheckPkg::*;

	ctrlStateT state;
	logic launched;   // start already issued for this run

	assign busy = (state == stTest);
	assign showing = (state == stShow);
	assign job.start = busy && !launched && (job.chip != chipNone);

	// ==================================================
	// run / test / show
	// ==================================================
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= stIdle;
			launched <= 1'b0;
			done <= 1'b0;
			verdict <= 1'b0;
		end
		else
		begin
			done <= 1'b0;   // single cycle pulse
			case (state)
				stIdle, stShow:
				begin
					if (run)
					begin
						state <= stTest;
						launched <= 1'b0;
					end
				end
				stTest:
				begin
					if (job.chip == chipNone)
					begin
						// nothing to drive, fail straight away
						verdict <= 1'b0;
						done <= 1'b1;
						state <= stShow;
					end
					else if (job.start)
						launched <= 1'b1;
					else if (job.done)
					begin
						verdict <= job.pass;
						done <= 1'b1;
						state <= stShow;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// code only moves when a run is accepted
	always_ff @(posedge Clk)
	begin
		if (run && !busy)
			code <= sel;
	end

endmodule

/* gateTester.sv */
module gateTester #(
	parameter int SettleCycles = 2
) (
	input logic Clk,
	input logic arstN,
	checkIf.tester job,
	input chipCheckPkg::pinVecT pinIn,
	output chipCheckPkg::pinVecT pinOut,
	output chipCheckPkg::pinVecT pinOe
);
	import chipCheckPkg::*;

	localparam int CntW = (SettleCycles > 1) ? $clog2(SettleCycles) : 1;

	logic active;
	vecIdxT vecIdx;
	vecIdxT lastIdx;
	logic [CntW-1:0] settleCnt;
	logic sampleNow;
	logic lastVec;
	logic passFlag;   // cleared on first mismatch
	logic doneR;
	logic passR;
	logic a;
	logic b;
	logic y;          // expected gate output for this vector
	logic badVec;
	pinVecT aMask;    // pins that take input a
	pinVecT bMask;    // pins that take input b
	pinVecT outMask;  // chip output pins
	pinVecT drive;
	pinVecT expPins;

	// ==================================================
	// pin map and truth table per chip
	// ==================================================
	always_comb
	begin
		a = vecIdx[0];
		b = vecIdx[1];
		lastIdx = 2'd3;
		case (job.chip)
			chip7400, chip7486:
			begin
				aMask = 14'b00_1001_0000_1001;   // 1 4 9 12
				bMask = 14'b01_0010_0001_0010;   // 2 5 10 13
				outMask = 14'b00_0100_1010_0100; // 3 6 8 11
				y = (job.chip == chip7486) ? (a ^ b) : ~(a & b);
			end
			chip7402:
			begin
				aMask = 14'b00_0100_1001_0010;   // 2 5 8 11
				bMask = 14'b00_1001_0010_0100;   // 3 6 9 12
				outMask = 14'b01_0010_0000_1001; // 1 4 10 13
				y = ~(a | b);
			end
			chip7404:
			begin
				aMask = 14'b01_0101_0001_0101;
				bMask = '0;
				outMask = 14'b00_1010_1010_1010; // even pins below 14
				y = ~a;
				lastIdx = 2'd1;   // only a toggles
			end
			default:
			begin
				aMask = '0;
				bMask = '0;
				outMask = '0;
				y = 1'b0;
			end
		endcase
	end

	assign drive = ({PinCount{a}} & aMask) | ({PinCount{b}} & bMask);
	assign expPins = {PinCount{y}} & outMask;
	assign badVec = |((pinIn ^ expPins) & outMask);

	assign sampleNow = active && (settleCnt == CntW'(SettleCycles - 1));
	assign lastVec = (vecIdx == lastIdx);

	assign pinOut = active ? drive : '0;
	assign pinOe = active ? job.oeMask : '0;
	assign job.done = doneR;
	assign job.pass = passR;

	// ==================================================
	// vector walk
	// ==================================================
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			active <= 1'b0;
			vecIdx <= '0;
			settleCnt <= '0;
			passFlag <= 1'b0;
			doneR <= 1'b0;
		end
		else
		begin
			doneR <= 1'b0;
			if (job.start)
			begin
				active <= 1'b1;
				vecIdx <= '0;
				settleCnt <= '0;
				passFlag <= 1'b1;
			end
			else if (active)
			begin
				if (sampleNow)
				begin
					settleCnt <= '0;
					if (badVec)
						passFlag <= 1'b0;
					if (lastVec)
					begin
						active <= 1'b0;
						doneR <= 1'b1;   // one cycle after last sample
					end
					else
						vecIdx <= vecIdx + 1'b1;
				end
				else
					settleCnt <= settleCnt + 1'b1;
			end
		end
	end

	// final verdict includes the last sample
	always_ff @(posedge Clk)
	begin
		if (sampleNow && lastVec)
			passR <= passFlag && !badVec;
	end

endmodule

/* resultDisplay.sv */
module resultDisplay (
	input chipCheckPkg::selCodeT sel,
	input logic showing,
	input logic verdict,
	output chipCheckPkg::segT hex0,
	output chipCheckPkg::segT hex1,
	output chipCheckPkg::segT hex2,
	output chipCheckPkg::segT hex3
);
	import chipCheckPkg::*;

	nibbleT resDigit;

	// active low, bits are g..a
	function automatic segT hexToSeg(input nibbleT n);
		case (n)
			4'h0: hexToSeg = 7'b100_0000;
			4'h1: hexToSeg = 7'b111_1001;
			4'h2: hexToSeg = 7'b010_0100;
			4'h3: hexToSeg = 7'b011_0000;
			4'h4: hexToSeg = 7'b001_1001;
			4'h5: hexToSeg = 7'b001_0010;
			4'h6: hexToSeg = 7'b000_0010;
			4'h7: hexToSeg = 7'b111_1000;
			4'h8: hexToSeg = 7'b000_0000;
			4'h9: hexToSeg = 7'b001_0000;
			4'hA: hexToSeg = 7'b000_1000;
			4'hB: hexToSeg = 7'b000_0011;   // lower case b
			4'hC: hexToSeg = 7'b100_0110;
			4'hD: hexToSeg = 7'b010_0001;   // lower case d
			4'hE: hexToSeg = 7'b000_0110;
			default: hexToSeg = 7'b000_1110;   // F
		endcase
	endfunction

	// A = pass, F = fail, 0 while idle or testing
	assign resDigit = showing ? (verdict ? 4'hA : 4'hF) : 4'h0;

	assign hex0 = hexToSeg(resDigit);
	assign hex1 = hexToSeg(resDigit);
	assign hex2 = hexToSeg(sel[3:0]);   // live switch digits
	assign hex3 = hexToSeg(sel[7:4]);

endmodule

/* chipChecker.sv */
module chipChecker #(
	parameter int SettleCycles = 2
) (
	input logic Clk,
	input logic arstN,
	input logic run,
	input chipCheckPkg::selCodeT sel,
	input chipCheckPkg::pinVecT pinIn,
	output chipCheckPkg::pinVecT pinOut,
	output chipCheckPkg::pinVecT pinOe,
	output logic busy,
	output logic done,
	output chipCheckPkg::segT hex0,
	output chipCheckPkg::segT hex1,
	output chipCheckPkg::segT hex2,
	output chipCheckPkg::segT hex3
);
	import chipCheckPkg::*;

	selCodeT code;   // latched at run
	logic showing;
	logic verdict;

	checkIf job ();

	chipDecode uDecode (
		.code (code),
		.job  (job.decode)
	);

	checkControl uControl (
		.Clk     (Clk),
		.arstN   (arstN),
		.run     (run),
		.sel     (sel),
		.code    (code),
		.job     (job.ctrl),
		.busy    (busy),
		.done    (done),
		.showing (showing),
		.verdict (verdict)
	);

	gateTester #(
		.SettleCycles (SettleCycles)
	) uTester (
		.Clk    (Clk),
		.arstN  (arstN),
		.job    (job.tester),
		.pinIn  (pinIn),
		.pinOut (pinOut),
		.pinOe  (pinOe)
	);

	resultDisplay uDisplay (
		.sel     (sel),
		.showing (showing),
		.verdict (verdict),
		.hex0    (hex0),
		.hex1    (hex1),
		.hex2    (hex2),
		.hex3    (hex3)
	);

endmodule

/* socketModel.sv */
module socketModel (
	input chipCheckPkg::chipT inserted,
	input logic faultEn,
	input logic [3:0] faultBit,   // pin number minus one
	input logic faultVal,
	input chipCheckPkg::pinVecT pinOut,
	input chipCheckPkg::pinVecT pinOe,
	output chipCheckPkg::pinVecT pinIn
);
	timeunit 1ns;
	timeprecision 100ps;
	import chipCheckPkg::*;

	pinVecT p;         // level the chip sees on each pin
	pinVecT chipOut;
	pinVecT outPins;

	function automatic logic gate(input chipT k, input logic x, input logic y);
		case (k)
			chip7400: gate = ~(x & y);
			chip7402: gate = ~(x | y);
			default: gate = x ^ y;
		endcase
	endfunction

	assign p = pinOut & pinOe;   // floating inputs read low

	always_comb
	begin
		chipOut = '0;
		outPins = '0;
		case (inserted)
			chip7400, chip7486:
			begin
				outPins = 14'h04A4;
				chipOut[2] = gate(inserted, p[0], p[1]);
				chipOut[5] = gate(inserted, p[3], p[4]);
				chipOut[7] = gate(inserted, p[8], p[9]);
				chipOut[10] = gate(inserted, p[11], p[12]);
			end
			chip7402:
			begin
				outPins = 14'h1209;
				chipOut[0] = gate(inserted, p[1], p[2]);
				chipOut[3] = gate(inserted, p[4], p[5]);
				chipOut[9] = gate(inserted, p[7], p[8]);
				chipOut[12] = gate(inserted, p[10], p[11]);
			end
			chip7404:
			begin
				outPins = 14'h0AAA;
				chipOut[1] = ~p[0];
				chipOut[3] = ~p[2];
				chipOut[5] = ~p[4];
				chipOut[7] = ~p[8];
				chipOut[9] = ~p[10];
				chipOut[11] = ~p[12];
			end
			default: chipOut = '0;   // empty socket
		endcase
		// stuck output only bites on a real output pin
		if (faultEn && outPins[faultBit])
			chipOut[faultBit] = faultVal;
	end

	assign pinIn = (pinOe & pinOut) | (~pinOe & chipOut);

endmodule

/* chipCheckerTb.sv */
module chipCheckerTb;
	timeunit 1ns;
	timeprecision 100ps;
	import chipCheckPkg::*;

	localparam int Settle = 2;
	localparam int NumRandom = 30;
	localparam int NumBad = 6;
	localparam int TotalTests = 1 + 4 + NumRandom + NumBad;

	// active low bits g..a per hex digit
	localparam segT SegTable [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
	localparam selCodeT KeptCodes [4] = '{8'h00, 8'h02, 8'h04, 8'h86};

	logic Clk;
	logic arstN;
	logic run;
	selCodeT sel;
	pinVecT pinIn;
	pinVecT pinOut;
	pinVecT pinOe;
	logic busy;
	logic done;
	segT hex0;
	segT hex1;
	segT hex2;
	segT hex3;
	chipT inserted;          // same part in both sockets
	logic faultEn;
	logic [3:0] faultBit;
	logic faultVal;
	pinVecT refOut;          // driven by the reference model
	pinVecT refOe;
	pinVecT refIn;

	chipChecker #(
		.SettleCycles (Settle)
	) dut (
		.Clk    (Clk),
		.arstN  (arstN),
		.run    (run),
		.sel    (sel),
		.pinIn  (pinIn),
		.pinOut (pinOut),
		.pinOe  (pinOe),
		.busy   (busy),
		.done   (done),
		.hex0   (hex0),
		.hex1   (hex1),
		.hex2   (hex2),
		.hex3   (hex3)
	);

	socketModel uSocket (
		.inserted (inserted),
		.faultEn  (faultEn),
		.faultBit (faultBit),
		.faultVal (faultVal),
		.pinOut   (pinOut),
		.pinOe    (pinOe),
		.pinIn    (pinIn)
	);

	socketModel uRefSocket (
		.inserted (inserted),
		.faultEn  (faultEn),
		.faultBit (faultBit),
		.faultVal (faultVal),
		.pinOut   (refOut),
		.pinOe    (refOe),
		.pinIn    (refIn)
	);

	initial
	begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	// ==================================================
	// compare and report
	// ==================================================
	task automatic stopWithError(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			stopWithError($sformatf("CHECK FAILED %s: expected %b, actual %b",
				name, expected, actual));
	endtask

	task automatic checkSeg(input string name, input segT expected, input segT actual);
		if (actual !== expected)
			stopWithError($sformatf("CHECK FAILED %s: expected %b, actual %b",
				name, expected, actual));
	endtask

	task automatic checkPins(input string name, input pinVecT expected, input pinVecT actual);
		if (actual !== expected)
			stopWithError($sformatf("CHECK FAILED %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	// ==================================================
	// reference model
	// ==================================================
	function automatic chipT chipOf(input selCodeT c);
		case (c)
			8'h00: chipOf = chip7400;
			8'h02: chipOf = chip7402;
			8'h04: chipOf = chip7404;
			8'h86: chipOf = chip7486;
			default: chipOf = chipNone;
		endcase
	endfunction

	// walk the vectors of chip k through the reference socket
	task automatic predictPass(input chipT k, output logic expPass);
		pinVecT aPins;
		pinVecT bPins;
		pinVecT outPins;
		logic a;
		logic b;
		logic y;
		int nVec;
		expPass = (k != chipNone);
		nVec = (k == chipNone) ? 0 : ((k == chip7404) ? 2 : 4);
		case (k)
			chip7400, chip7486:
			begin
				aPins = 14'h0909;
				bPins = 14'h1212;
				outPins = 14'h04A4;
			end
			chip7402:
			begin
				aPins = 14'h0492;
				bPins = 14'h0924;
				outPins = 14'h1209;
			end
			default:
			begin
				aPins = 14'h1515;   // 7404 pin map
				bPins = '0;
				outPins = 14'h0AAA;
			end
		endcase
		for (int v = 0; v < nVec; v++)
		begin
			a = v[0];
			b = v[1];
			case (k)
				chip7400: y = ~(a & b);
				chip7402: y = ~(a | b);
				chip7404: y = ~a;
				default: y = a ^ b;
			endcase
			refOe = aPins | bPins;
			refOut = ({PinCount{a}} & aPins) | ({PinCount{b}} & bPins);
			#0.2;
			if ((refIn & outPins) != ({PinCount{y}} & outPins))
				expPass = 1'b0;
		end
	endtask

	// one run with run and sel poked while busy
	task automatic runTest(input string name, input selCodeT code, input logic expPass,
		input logic noDrive);
		segT expRes;
		expRes = expPass ? SegTable[4'hA] : SegTable[4'hF];
		@(negedge Clk);
		sel = code;
		run = 1'b1;
		@(negedge Clk);
		run = 1'b0;
		checkBit({name, " busy rise"}, 1'b1, busy);
		while (!done)
		begin
			checkBit({name, " busy"}, 1'b1, busy);
			checkSeg({name, " hex3"}, SegTable[sel[7:4]], hex3);
			checkSeg({name, " hex2"}, SegTable[sel[3:0]], hex2);
			if (noDrive)
			begin
				checkPins({name, " pinOe"}, '0, pinOe);
				checkPins({name, " pinOut"}, '0, pinOut);
			end
			run = 1'($urandom_range(0, 1));   // must be ignored
			sel = selCodeT'($urandom);
			@(negedge Clk);
			run = 1'b0;
		end
		checkBit({name, " busy fall"}, 1'b0, busy);
		checkSeg({name, " hex1"}, expRes, hex1);
		checkSeg({name, " hex0"}, expRes, hex0);
		if (noDrive)
		begin
			checkPins({name, " pinOe at done"}, '0, pinOe);
			checkPins({name, " pinOut at done"}, '0, pinOut);
		end
		repeat (3)
		begin
			@(negedge Clk);
			checkBit({name, " single done"}, 1'b0, done);
			checkSeg({name, " verdict held"}, expRes, hex0);
		end
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial
	begin
		logic expPass;
		selCodeT code;
		void'($urandom(47));
		arstN = 1'b0;
		run = 1'b0;
		sel = '0;
		inserted = chipNone;
		faultEn = 1'b0;
		faultBit = '0;
		faultVal = 1'b0;
		refOut = '0;
		refOe = '0;
		repeat (8) @(negedge Clk);
		arstN = 1'b1;
		@(negedge Clk);
		checkBit("reset busy", 1'b0, busy);
		checkBit("reset done", 1'b0, done);
		checkPins("reset pinOe", '0, pinOe);
		checkPins("reset pinOut", '0, pinOut);
		checkSeg("reset hex3", SegTable[sel[7:4]], hex3);
		checkSeg("reset hex2", SegTable[sel[3:0]], hex2);
		checkSeg("reset hex1", SegTable[0], hex1);
		checkSeg("reset hex0", SegTable[0], hex0);
		for (int i = 0; i < 4; i++)
		begin
			inserted = chipOf(KeptCodes[2'(i)]);   // good part without fault
			runTest($sformatf("match %h", KeptCodes[2'(i)]), KeptCodes[2'(i)], 1'b1, 1'b0);
		end
		for (int i = 0; i < NumRandom; i++)
		begin
			code = KeptCodes[2'($urandom_range(0, 3))];
			inserted = chipT'(3'($urandom_range(0, 4)));
			faultEn = 1'($urandom_range(0, 1));
			faultBit = 4'($urandom_range(0, 13));
			faultVal = 1'($urandom_range(0, 1));
			predictPass(chipOf(code), expPass);
			runTest($sformatf("random %0d sel %h in %s", i, code, inserted.name()),
				code, expPass, 1'b0);
		end
		faultEn = 1'b0;
		for (int i = 0; i < NumBad; i++)
		begin
			do
				code = selCodeT'($urandom);
			while (chipOf(code) != chipNone);
			inserted = chipT'(3'($urandom_range(1, 4)));
			runTest($sformatf("unsupported %h", code), code, 1'b0, 1'b1);
		end
		$display("No errors");
		$finish;
	end

	// watchdog allows 60 cycles per test
	initial
	begin
		repeat (TotalTests * 60) @(posedge Clk);
		stopWithError($sformatf("timeout, tests did not finish within %0d cycles",
			TotalTests * 60));
	end

endmodule

/* build.f */
chipCheckPkg.sv
checkIf.sv
chipDecode.sv
checkControl.sv
gateTester.sv
resultDisplay.sv
chipChecker.sv
socketModel.sv
chipCheckerTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps -f build.f \
	--top-module chipCheckerTb -o simChipChecker
./obj_dir/simChipChecker | tee sim.log
if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"
